/* Makefile */
TOP  := tb_ecc_loopback
SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
	  --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* filelist.f */
source/ecc_code_pkg.sv
source/ecc_link_pkg.sv
source/secded_encoder.sv
source/fault_injector.sv
source/secded_decoder.sv
source/ecc_loopback_top.sv
testbench/tb_clock_gen.sv
testbench/ecc_loopback_sva.sv
testbench/tb_ecc_loopback.sv

/* source/ecc_code_pkg.sv */
/*
 * Fixed Hsiao SECDED code, 16 data bits and 6 parity bits, no other widths
 * Every data column has weight 3 and each row of the check matrix has 8 ones
 */
package ecc_code_pkg;

  // Code dimensions
  localparam int data_width     = 16;
  localparam int parity_width   = 6;
  localparam int codeword_width = data_width + parity_width;

  // Index into the 22-bit codeword
  localparam int pos_width = 5;

  // Parity-check columns of the data bits
  // Entry i is the syndrome seen when data bit i flips
  // Four of the twenty weight-3 columns are dropped to balance the rows
  localparam logic [parity_width-1:0] hsiao_columns [0:data_width-1] = '{
    6'h0b,
    6'h0d,
    6'h0e,
    6'h13,
    6'h15,
    6'h16,
    6'h1a,
    6'h1c,
    6'h23,
    6'h25,
    6'h29,
    6'h2a,
    6'h2c,
    6'h31,
    6'h32,
    6'h34
  };

  // Parity of a data word
  // Row j of the result is the XOR of data bits whose column has row j set
  function automatic logic [parity_width-1:0] calc_parity(
    input logic [data_width-1:0] d
  );
    logic [parity_width-1:0] p;
    p = '0;
    for (int i = 0; i < data_width; i++) begin
      // Each set data bit adds its column
      if (d[i]) begin
        p = p ^ hsiao_columns[i];
      end
    end
    return p;
  endfunction

endpackage

/* source/ecc_link_pkg.sv */
/*
 * Types carried between encoder, injector and decoder
 * Codeword order is parity above data, so bits 0 to 15 are data
 */
package ecc_link_pkg;

  // Injector opcode
  typedef enum logic [1:0] {
    inj_none,
    inj_single,
    inj_double
  } inject_mode_e;

  // Fault command, sampled together with the data word
  // Positions must be distinct and below 22, nothing checks this
  typedef struct packed {
    inject_mode_e                          mode;
    logic [ecc_code_pkg::pos_width-1:0]    pos_a;
    logic [ecc_code_pkg::pos_width-1:0]    pos_b;
  } inject_cmd_t;

  // Codeword with its strobe
  typedef struct packed {
    logic                                  valid;
    logic [ecc_code_pkg::parity_width-1:0] parity;
    logic [ecc_code_pkg::data_width-1:0]   data;
  } codeword_t;

  // Decoder output
  // ce marks a corrected error, due an uncorrectable one
  typedef struct packed {
    logic                                  valid;
    logic [ecc_code_pkg::data_width-1:0]   data;
    logic [ecc_code_pkg::parity_width-1:0] syndrome;
    logic                                  ce;
    logic                                  due;
  } dec_result_t;

endpackage

/* source/ecc_loopback_top.sv */
/*
 * Encoder, fault injector and decoder in a row, four cycles input to result
 * No back-pressure, one result per valid input, in order
 */
module ecc_loopback_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                data_valid,
  input  logic [ecc_code_pkg::data_width-1:0] data,
  input  ecc_link_pkg::inject_cmd_t           cmd,
  output ecc_link_pkg::dec_result_t           result
);

  import ecc_link_pkg::*;

  // Encoder to injector
  codeword_t enc_word;

  // Injector to decoder
  codeword_t rcv_word;

  // Cycle 1
  secded_encoder i_secded_encoder (
    .clk,
    .rst_n,
    .data_valid,
    .data,
    .enc_word
  );

  // Cycle 2, command delayed inside to match the data
  fault_injector i_fault_injector (
    .clk,
    .rst_n,
    .cmd,
    .enc_word,
    .rcv_word
  );

  // Cycles 3 and 4
  secded_decoder i_secded_decoder (
    .clk,
    .rst_n,
    .rcv_word,
    .result
  );

endmodule

/* source/fault_injector.sv */
/*
 * Flips zero, one or two codeword bits, one cycle of latency
 * Positions are taken as given, out-of-range positions flip nothing
 */
module fault_injector (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ecc_link_pkg::inject_cmd_t cmd,
  input  ecc_link_pkg::codeword_t   enc_word,
  output ecc_link_pkg::codeword_t   rcv_word
);

  import ecc_code_pkg::*;
  import ecc_link_pkg::*;

  // Command delayed to line up with the encoder output
  inject_cmd_t cmd_q;

  // Bits to flip
  logic [codeword_width-1:0] flip_mask;

  // Codeword before and after the fault
  logic [codeword_width-1:0] clean_bits;
  logic [codeword_width-1:0] faulty_bits;

  // Command delay
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_q.mode <= inj_none;
    end else begin
      cmd_q.mode <= cmd.mode;
    end
    cmd_q.pos_a <= cmd.pos_a;
    cmd_q.pos_b <= cmd.pos_b;
  end

  // Mask decode from mode and positions
  always_comb begin
    for (int i = 0; i < codeword_width; i++) begin
      flip_mask[i] = ((cmd_q.mode != inj_none) && (cmd_q.pos_a == pos_width'(i))) ||
                     ((cmd_q.mode == inj_double) && (cmd_q.pos_b == pos_width'(i)));
    end
  end

  // Flat codeword, parity over data
  assign clean_bits  = {enc_word.parity, enc_word.data};
  assign faulty_bits = clean_bits ^ flip_mask;

  // Strobe passes through
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rcv_word.valid <= 1'b0;
    end else begin
      rcv_word.valid <= enc_word.valid;
    end
  end

  // Faulty payload
  always_ff @(posedge clk) begin
    rcv_word.parity <= faulty_bits[codeword_width-1:data_width];
    rcv_word.data   <= faulty_bits[data_width-1:0];
  end

endmodule

/* source/secded_decoder.sv */
/*
 * Two-cycle SECDED decoder: syndrome register, then correction and flags
 * Errors of three or more bits may be miscorrected or pass as clean
 */
module secded_decoder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ecc_link_pkg::codeword_t   rcv_word,
  output ecc_link_pkg::dec_result_t result
);

  import ecc_code_pkg::*;

  // Stage 1 registers
  logic                    s1_valid;
  logic [data_width-1:0]   s1_data;
  logic [parity_width-1:0] s1_syndrome;

  // Stage 1 syndrome
  logic [parity_width-1:0] syndrome;

  // Stage 2 lookup
  logic [data_width-1:0]   data_match;
  logic                    data_hit;
  logic                    parity_hit;
  logic                    syn_odd;
  logic                    syn_nonzero;
  logic                    corr_err;
  logic                    uncorr_err;
  logic [data_width-1:0]   corr_data;

  // Received parity against parity rebuilt from received data
  always_comb begin
    syndrome = rcv_word.parity ^ calc_parity(rcv_word.data);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= rcv_word.valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_data     <= rcv_word.data;
    s1_syndrome <= syndrome;
  end

  // Column match, one hot at most since columns are distinct
  always_comb begin
    for (int i = 0; i < data_width; i++) begin
      data_match[i] = (s1_syndrome == hsiao_columns[i]);
    end
  end

  assign data_hit    = |data_match;
  // Unit vector means a flipped parity bit
  assign parity_hit  = $onehot(s1_syndrome);
  assign syn_odd     = ^s1_syndrome;
  assign syn_nonzero = |s1_syndrome;

  // Odd weight and a known column
  assign corr_err   = syn_odd && (data_hit || parity_hit);
  // Even weight, or odd with no matching column
  assign uncorr_err = syn_nonzero && !corr_err;

  // Only a data column hit changes the data
  assign corr_data = s1_data ^ (data_match & {data_width{corr_err}});

  // Result register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result.valid <= 1'b0;
      result.ce    <= 1'b0;
      result.due   <= 1'b0;
    end else begin
      result.valid <= s1_valid;
      result.ce    <= corr_err;
      result.due   <= uncorr_err;
    end
  end

  always_ff @(posedge clk) begin
    result.data     <= corr_data;
    result.syndrome <= s1_syndrome;
  end

endmodule

/* source/secded_encoder.sv */
/*
 * One-cycle SECDED encoder, no back-pressure
 * Payload is loaded only on data_valid and holds otherwise
 */
module secded_encoder (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                data_valid,
  input  logic [ecc_code_pkg::data_width-1:0] data,
  output ecc_link_pkg::codeword_t             enc_word
);

  import ecc_code_pkg::*;

  // Parity of the incoming word
  logic [parity_width-1:0] parity;

  always_comb begin
    parity = calc_parity(data);
  end

  // Strobe register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enc_word.valid <= 1'b0;
    end else begin
      enc_word.valid <= data_valid;
    end
  end

  // Payload register
  // Parity sits above the data in the codeword
  always_ff @(posedge clk) begin
    if (data_valid) begin
      enc_word.parity <= parity;
      enc_word.data   <= data;
    end
  end

endmodule

/* testbench/ecc_loopback_sva.sv */
/*
 * Decoder output assertions, bound into every secded_decoder
 * Flag checks are off while rst_n is low
 */
module ecc_loopback_sva (
  input logic                      clk,
  input logic                      rst_n,
  input ecc_link_pkg::dec_result_t result
);

  timeunit 1ns;
  timeprecision 100ps;

  // A word is either corrected or uncorrectable, never both
  flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(result.ce && result.due)
  ) else $error("ce and due are set in the same cycle");

  // Clean syndrome means no error flag
  clean_no_flags: assert property (
    @(posedge clk) disable iff (!rst_n)
    (result.valid && (result.syndrome == '0)) |-> (!result.ce && !result.due)
  ) else $error("flag set on a valid result with zero syndrome");

  // Reset clears the output strobe
  valid_low_after_reset: assert property (
    @(posedge clk)
    !rst_n |=> !result.valid
  ) else $error("result.valid is set in the cycle after reset");

endmodule

bind secded_decoder ecc_loopback_sva i_ecc_loopback_sva (
  .clk    (clk),
  .rst_n  (rst_n),
  .result (result)
);

/* testbench/tb_clock_gen.sv */
/*
 * 100 ns clock, rst_n low for the first 8 rising edges
 * Reset is released 10 ns after the 8th edge
 */
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int period_ns    = 100;
  localparam int reset_cycles = 8;

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

  // Synchronous reset, released away from the edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #10 rst_n = 1'b1;
  end

endmodule

/* testbench/tb_ecc_loopback.sv */
/*
 * Random loopback test of the SECDED path from a fixed LCG seed
 * Expected results come from a model of the Hsiao code rules
 */
module tb_ecc_loopback;

  timeunit 1ns;
  timeprecision 100ps;

  import ecc_code_pkg::*;
  import ecc_link_pkg::*;

  localparam int period_ns       = 100;
  localparam int reset_cycles    = 8;
  localparam int stim_cycles     = 2000;
  localparam int drain_cycles    = 6;
  // Drive cycle to the cycle where result.valid is seen
  localparam int latency         = 4;
  localparam int watchdog_cycles = reset_cycles + stim_cycles + 20;

  logic                  clk;
  logic                  rst_n;
  logic                  data_valid;
  logic [data_width-1:0] data;
  inject_cmd_t           cmd;
  dec_result_t           result;

  // LCG state
  logic [31:0] rng_state;
  // Rising edges seen so far
  int cycle_cnt = 0;

  // Expected results and the cycle each one is due
  dec_result_t exp_q[$];
  int          due_q[$];

  // Fault classes driven
  int n_clean;
  int n_data_err;
  int n_parity_err;
  int n_double;

  tb_clock_gen i_tb_clock_gen (
    .clk,
    .rst_n
  );

  ecc_loopback_top i_ecc_loopback_top (
    .clk,
    .rst_n,
    .data_valid,
    .data,
    .cmd,
    .result
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Upper LCG bits only since the low ones have short periods
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {8'h00, rng_state[31:8]};
  endfunction

  // Syndrome contribution of one codeword bit
  function automatic logic [parity_width-1:0] column_of(input int pos);
    logic [parity_width-1:0] col;
    if (pos < data_width) begin
      col = hsiao_columns[pos[3:0]];
    end else begin
      // Parity bit j gives the unit vector at j
      col = parity_width'(1) << (pos - data_width);
    end
    return col;
  endfunction

  // Reference decode of one word under one fault command
  function automatic dec_result_t build_expected(
    input logic [data_width-1:0] d,
    input inject_cmd_t           c
  );
    dec_result_t             res;
    logic [parity_width-1:0] syn;
    logic [data_width-1:0]   rx_data;
    int                      pos_a;
    int                      pos_b;
    pos_a   = int'(c.pos_a);
    pos_b   = int'(c.pos_b);
    rx_data = d;
    syn     = '0;
    // Shift past bit 15 gives zero so parity flips leave the data alone
    if (c.mode != inj_none) begin
      syn     = syn ^ column_of(pos_a);
      rx_data = rx_data ^ (data_width'(1) << pos_a);
    end
    if (c.mode == inj_double) begin
      syn     = syn ^ column_of(pos_b);
      rx_data = rx_data ^ (data_width'(1) << pos_b);
    end
    res.valid    = 1'b1;
    res.data     = rx_data;
    res.syndrome = syn;
    res.ce       = 1'b0;
    res.due      = 1'b0;
    if (syn != '0) begin
      // Uncorrectable unless an odd syndrome names a column
      res.due = 1'b1;
      if (($countones(syn) % 2) == 1) begin
        if ($countones(syn) == 1) begin
          res.ce  = 1'b1;
          res.due = 1'b0;
        end
        for (int i = 0; i < data_width; i++) begin
          if (syn == hsiao_columns[i[3:0]]) begin
            res.data = rx_data ^ (data_width'(1) << i);
            res.ce   = 1'b1;
            res.due  = 1'b0;
          end
        end
      end
    end
    return res;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_payload(input dec_result_t got, input dec_result_t expected);
    if (got.data !== expected.data) begin
      stop_on_error($sformatf("error at %0t ns: result.data got %h expected %h",
                              $time, got.data, expected.data));
    end
    if (got.syndrome !== expected.syndrome) begin
      stop_on_error($sformatf("error at %0t ns: result.syndrome got %h expected %h",
                              $time, got.syndrome, expected.syndrome));
    end
  endtask

  task automatic check_flags(input dec_result_t got, input dec_result_t expected);
    if (got.ce !== expected.ce) begin
      stop_on_error($sformatf("error at %0t ns: result.ce got %b expected %b",
                              $time, got.ce, expected.ce));
    end
    if (got.due !== expected.due) begin
      stop_on_error($sformatf("error at %0t ns: result.due got %b expected %b",
                              $time, got.due, expected.due));
    end
  endtask

  task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
      stop_on_error($sformatf("error at %0t ns: result.valid cycle got %0d expected %0d",
                              $time, got, expected));
    end
  endtask

  // One random cycle with valid set about 80% of the time
  task automatic drive_random_item();
    logic [data_width-1:0] d;
    inject_cmd_t           c;
    logic [31:0]           sel;
    int                    pos_a;
    int                    pos_b;
    d     = data_width'(next_rand());
    pos_a = int'(next_rand() % 32'd22);
    // Offset of 1 to 21 keeps the two positions distinct
    pos_b = (pos_a + 1 + int'(next_rand() % 32'd21)) % codeword_width;
    sel   = next_rand() % 32'd3;
    case (sel)
      32'd0:   c.mode = inj_none;
      32'd1:   c.mode = inj_single;
      default: c.mode = inj_double;
    endcase
    c.pos_a    = pos_width'(pos_a);
    c.pos_b    = pos_width'(pos_b);
    data       = d;
    cmd        = c;
    data_valid = (next_rand() % 32'd10) < 32'd8;
    if (data_valid) begin
      exp_q.push_back(build_expected(d, c));
      due_q.push_back(cycle_cnt + latency);
      if (c.mode == inj_none) begin
        n_clean++;
      end else if (c.mode == inj_double) begin
        n_double++;
      end else if (pos_a < data_width) begin
        n_data_err++;
      end else begin
        n_parity_err++;
      end
    end
  endtask

  // Output monitor at mid-cycle where result is stable
  always @(negedge clk) begin
    dec_result_t expected;
    int          due_cycle;
    if (rst_n === 1'b1) begin
      if (result.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          stop_on_error("result.valid was set with no input in flight");
        end else begin
          expected  = exp_q.pop_front();
          due_cycle = due_q.pop_front();
          check_latency(cycle_cnt, due_cycle);
          check_payload(result, expected);
          check_flags(result, expected);
        end
      end else if (result.valid !== 1'b0) begin
        stop_on_error("result.valid is unknown after reset");
      end else if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
        stop_on_error("an input never produced its result");
      end
    end
  end

  // Stimulus and end of run
  initial begin
    rng_state    = 32'd15743;
    data_valid   = 1'b0;
    data         = '0;
    cmd.mode     = inj_none;
    cmd.pos_a    = '0;
    cmd.pos_b    = '0;
    n_clean      = 0;
    n_data_err   = 0;
    n_parity_err = 0;
    n_double     = 0;
    wait (rst_n === 1'b1);
    for (int n = 0; n < stim_cycles; n++) begin
      @(posedge clk);
      #10;
      drive_random_item();
    end
    @(posedge clk);
    #10 data_valid = 1'b0;
    // Fixed pipeline depth means a few idle cycles drain it
    repeat (drain_cycles) @(posedge clk);
    #10;
    if (exp_q.size() != 0) begin
      stop_on_error($sformatf("%0d results never arrived", exp_q.size()));
    end else if (n_clean == 0 || n_data_err == 0 || n_parity_err == 0 || n_double == 0) begin
      stop_on_error("a fault class was never driven");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * period_ns);
    stop_on_error("watchdog expired before the test finished");
  end

endmodule
